/* hw/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;      // data, address and instruction
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  byte_t;      // one bus beat
    typedef logic [4:0]  opcode_t;    // instr[6:2]
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic        op_a_sel_t;
    typedef logic [1:0]  op_b_sel_t;
    typedef logic [1:0]  wb_sel_t;

    // major opcodes with the low two bits dropped
    localparam opcode_t op_load   = 5'b00000;
    localparam opcode_t op_opimm  = 5'b00100;
    localparam opcode_t op_auipc  = 5'b00101;
    localparam opcode_t op_store  = 5'b01000;
    localparam opcode_t op_op     = 5'b01100;
    localparam opcode_t op_lui    = 5'b01101;
    localparam opcode_t op_branch = 5'b11000;
    localparam opcode_t op_jalr   = 5'b11001;
    localparam opcode_t op_jal    = 5'b11011;

    // branch conditions
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    // alu functions, shared by OP and OP-IMM
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    localparam alu_op_t alu_add  = 4'd0;
    localparam alu_op_t alu_sub  = 4'd1;
    localparam alu_op_t alu_sll  = 4'd2;
    localparam alu_op_t alu_slt  = 4'd3;
    localparam alu_op_t alu_sltu = 4'd4;
    localparam alu_op_t alu_xor  = 4'd5;
    localparam alu_op_t alu_srl  = 4'd6;
    localparam alu_op_t alu_sra  = 4'd7;
    localparam alu_op_t alu_or   = 4'd8;
    localparam alu_op_t alu_and  = 4'd9;

    localparam op_a_sel_t sel_a_reg = 1'b0;
    localparam op_a_sel_t sel_a_pc  = 1'b1;

    localparam op_b_sel_t sel_b_reg  = 2'd0;
    localparam op_b_sel_t sel_b_imm  = 2'd1;
    localparam op_b_sel_t sel_b_four = 2'd2;

    localparam wb_sel_t wb_alu = 2'd0;
    localparam wb_sel_t wb_bus = 2'd1;
    localparam wb_sel_t wb_imm = 2'd2;

    localparam word_t reset_vector = 32'h0000_0000;
    localparam word_t instr_len    = 32'd4;

endpackage

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t   result,
    output logic             eq,
    output logic             lt,
    output logic             ltu
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];    // only low five bits count

    // flags always valid, branches read them
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {31'b0, lt};
            alu_sltu: result = {31'b0, ltu};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;   // keeps the sign bit
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

/* hw/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  logic               clk,
    input  logic               en,
    input  cpu_pkg::word_t     instr,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::reg_addr_t rd,
    output cpu_pkg::word_t     imm,
    output cpu_pkg::opcode_t   opcode,
    output cpu_pkg::funct3_t   funct3,
    output logic               funct7_b5
);
    import cpu_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    word_t imm_sel;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // format follows the raw opcode
    always_comb begin
        case (instr[6:2])
            op_store:         imm_sel = imm_s;
            op_branch:        imm_sel = imm_b;
            op_lui, op_auipc: imm_sel = imm_u;
            op_jal:           imm_sel = imm_j;
            default:          imm_sel = imm_i;   // op-imm, load, jalr
        endcase
    end

    // fields held until the next en
    always_ff @(posedge clk) begin
        if (en) begin
            opcode    <= instr[6:2];
            rd        <= instr[11:7];
            funct3    <= instr[14:12];
            rs1       <= instr[19:15];
            rs2       <= instr[24:20];
            funct7_b5 <= instr[30];   // sub and sra select
            imm       <= imm_sel;
        end
    end

endmodule

/* hw/registers.sv */
`timescale 1ns/1ps

module registers (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    input  cpu_pkg::reg_addr_t rd,
    input  logic               re,
    input  logic               we,
    input  cpu_pkg::word_t     wdata,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2
);
    import cpu_pkg::*;

    word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (we && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
        if (re) begin
            rdata1 <= (rs1 == 5'd0) ? '0 : regs[rs1];
            rdata2 <= (rs2 == 5'd0) ? '0 : regs[rs2];
        end
    end

endmodule

/* hw/bus_wb8.sv */
`timescale 1ns/1ps

module bus_wb8 (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           write,
    input  cpu_pkg::word_t addr,
    input  cpu_pkg::word_t wdata,
    output cpu_pkg::word_t rdata,
    output logic           done,
    input  cpu_pkg::byte_t wb_dat_rd,
    input  logic           wb_ack,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::byte_t wb_dat_wr,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {b_idle, b_beat, b_gap, b_finish} bus_state_t;

    bus_state_t state;
    logic [1:0] beat;      // byte lane of the current beat
    word_t      addr_q;
    word_t      wdata_q;

    // little-endian, byte 0 goes out first
    assign wb_adr    = addr_q + {30'b0, beat};
    assign wb_dat_wr = wdata_q[{beat, 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= b_idle;
            beat   <= 2'd0;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                b_idle: if (start) begin
                    wb_cyc <= 1'b1;
                    wb_stb <= 1'b1;
                    wb_we  <= write;
                    beat   <= 2'd0;
                    state  <= b_beat;
                end
                b_beat: if (wb_ack) begin
                    wb_stb <= 1'b0;   // one idle cycle between beats
                    beat   <= beat + 2'd1;
                    state  <= (beat == 2'd3) ? b_finish : b_gap;
                end
                b_gap: begin
                    wb_stb <= 1'b1;
                    state  <= b_beat;
                end
                default: begin   // b_finish
                    wb_cyc <= 1'b0;
                    wb_we  <= 1'b0;
                    done   <= 1'b1;
                    state  <= b_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == b_idle) && start) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if ((state == b_beat) && wb_ack && !wb_we) begin
            rdata[{beat, 3'b000} +: 8] <= wb_dat_rd;
        end
    end

endmodule

/* hw/control.sv */
`timescale 1ns/1ps

module control (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::opcode_t    opcode,
    input  cpu_pkg::funct3_t    funct3,
    input  logic                funct7_b5,
    input  logic                alu_eq,
    input  logic                alu_lt,
    input  logic                alu_ltu,
    input  cpu_pkg::word_t      alu_result,
    input  logic                bus_done,
    output cpu_pkg::word_t      pc,
    output cpu_pkg::alu_op_t    alu_op,
    output cpu_pkg::op_a_sel_t  op_a_sel,
    output cpu_pkg::op_b_sel_t  op_b_sel,
    output cpu_pkg::wb_sel_t    wb_sel,
    output logic                bus_addr_sel,
    output logic                bus_start,
    output logic                bus_write,
    output logic                dec_en,
    output logic                reg_re,
    output logic                reg_we
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        s_fetch, s_fetch_wait, s_decode, s_exec,
        s_mem, s_writeback, s_branch, s_pc_update
    } state_t;

    state_t  state;
    word_t   next_pc;
    alu_op_t func_op;
    logic    taken;

    always_comb begin
        case (funct3)
            f3_add_sub: func_op = ((opcode == op_op) && funct7_b5) ? alu_sub : alu_add;
            f3_sll:     func_op = alu_sll;
            f3_slt:     func_op = alu_slt;
            f3_sltu:    func_op = alu_sltu;
            f3_xor:     func_op = alu_xor;
            f3_srl_sra: func_op = funct7_b5 ? alu_sra : alu_srl;
            f3_or:      func_op = alu_or;
            f3_and:     func_op = alu_and;
            default:    func_op = alu_add;
        endcase
    end

    always_comb begin
        case (funct3)
            f3_beq:  taken = alu_eq;
            f3_bne:  taken = !alu_eq;
            f3_blt:  taken = alu_lt;
            f3_bge:  taken = !alu_lt;
            f3_bltu: taken = alu_ltu;
            f3_bgeu: taken = !alu_ltu;
            default: taken = 1'b0;
        endcase
    end

    assign bus_write    = (state == s_mem) && (opcode == op_store);
    assign bus_addr_sel = (state != s_mem);   // high picks the pc

    // datapath selects follow the current state
    always_comb begin
        alu_op   = alu_add;
        op_a_sel = sel_a_reg;
        op_b_sel = sel_b_reg;
        wb_sel   = wb_alu;
        dec_en   = 1'b0;
        reg_re   = 1'b0;
        reg_we   = 1'b0;
        case (state)
            s_decode: begin
                dec_en   = 1'b1;
                op_a_sel = sel_a_pc;   // ALU is free, compute pc + 4
                op_b_sel = sel_b_four;
            end
            s_exec:  reg_re = 1'b1;
            s_mem:   op_b_sel = sel_b_imm;   // rs1 + offset
            s_writeback: begin
                reg_we = 1'b1;
                case (opcode)
                    op_op:    alu_op = func_op;
                    op_opimm: begin
                        alu_op   = func_op;
                        op_b_sel = sel_b_imm;
                    end
                    op_load:  wb_sel = wb_bus;
                    op_lui:   wb_sel = wb_imm;
                    op_auipc: begin
                        op_a_sel = sel_a_pc;
                        op_b_sel = sel_b_imm;
                    end
                    default: begin
                        op_a_sel = sel_a_pc;   // link address for jal and jalr
                        op_b_sel = sel_b_four;
                    end
                endcase
            end
            s_pc_update: begin
                op_a_sel = (opcode == op_jalr) ? sel_a_reg : sel_a_pc;
                op_b_sel = sel_b_imm;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= s_fetch;
            pc        <= reset_vector;
            bus_start <= 1'b0;
        end else begin
            bus_start <= 1'b0;
            case (state)
                s_fetch: begin
                    bus_start <= 1'b1;
                    state     <= s_fetch_wait;
                end
                s_fetch_wait: if (bus_done) state <= s_decode;
                s_decode: state <= s_exec;
                s_exec: begin
                    case (opcode)
                        op_op, op_opimm, op_lui, op_auipc, op_jal, op_jalr: begin
                            state <= s_writeback;
                        end
                        op_load, op_store: begin
                            bus_start <= 1'b1;
                            state     <= s_mem;
                        end
                        op_branch: state <= s_branch;
                        default: begin   // anything else runs as a nop
                            pc    <= next_pc;
                            state <= s_fetch;
                        end
                    endcase
                end
                s_mem: if (bus_done) begin
                    if (opcode == op_load) begin
                        state <= s_writeback;
                    end else begin
                        pc    <= next_pc;
                        state <= s_fetch;
                    end
                end
                s_writeback: begin
                    if ((opcode == op_jal) || (opcode == op_jalr)) begin
                        state <= s_pc_update;
                    end else begin
                        pc    <= next_pc;
                        state <= s_fetch;
                    end
                end
                s_branch: begin
                    if (taken) begin
                        state <= s_pc_update;
                    end else begin
                        pc    <= next_pc;
                        state <= s_fetch;
                    end
                end
                default: begin   // s_pc_update, fetch starts right away
                    pc        <= {alu_result[31:1], 1'b0};
                    bus_start <= 1'b1;
                    state     <= s_fetch_wait;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_decode) next_pc <= alu_result;
    end

endmodule

/* hw/cpu.sv */
`timescale 1ns/1ps

module cpu (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::byte_t wb_dat_rd,
    input  logic           wb_ack,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::byte_t wb_dat_wr,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we
);
    import cpu_pkg::*;

    word_t     pc, alu_a, alu_b, alu_result;
    word_t     bus_addr, bus_rdata, reg_wdata;
    word_t     rdata1, rdata2, dec_imm;
    alu_op_t   alu_op;
    op_a_sel_t op_a_sel;
    op_b_sel_t op_b_sel;
    wb_sel_t   wb_sel;
    logic      alu_eq, alu_lt, alu_ltu;
    logic      bus_addr_sel, bus_start, bus_write, bus_done;
    logic      dec_en, reg_re, reg_we;
    reg_addr_t dec_rs1, dec_rs2, dec_rd;
    opcode_t   dec_opcode;
    funct3_t   dec_funct3;
    logic      dec_funct7_b5;

    always_comb begin
        case (op_a_sel)
            sel_a_reg: alu_a = rdata1;
            default:   alu_a = pc;
        endcase
        case (op_b_sel)
            sel_b_reg: alu_b = rdata2;
            sel_b_imm: alu_b = dec_imm;
            default:   alu_b = instr_len;
        endcase
        bus_addr = bus_addr_sel ? pc : alu_result;
        case (wb_sel)
            wb_bus:  reg_wdata = bus_rdata;
            wb_imm:  reg_wdata = dec_imm;   // lui
            default: reg_wdata = alu_result;
        endcase
    end

    control i_control (
        .clk, .reset,
        .opcode(dec_opcode), .funct3(dec_funct3), .funct7_b5(dec_funct7_b5),
        .alu_eq, .alu_lt, .alu_ltu, .alu_result, .bus_done,
        .pc, .alu_op, .op_a_sel, .op_b_sel, .wb_sel, .bus_addr_sel,
        .bus_start, .bus_write, .dec_en, .reg_re, .reg_we
    );

    alu i_alu (
        .a(alu_a), .b(alu_b), .op(alu_op),
        .result(alu_result), .eq(alu_eq), .lt(alu_lt), .ltu(alu_ltu)
    );

    // instruction word comes straight from the bus master
    decoder i_decoder (
        .clk, .en(dec_en), .instr(bus_rdata),
        .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .imm(dec_imm),
        .opcode(dec_opcode), .funct3(dec_funct3), .funct7_b5(dec_funct7_b5)
    );

    registers i_registers (
        .clk, .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .re(reg_re), .we(reg_we), .wdata(reg_wdata),
        .rdata1, .rdata2
    );

    bus_wb8 i_bus (
        .clk, .reset,
        .start(bus_start), .write(bus_write), .addr(bus_addr), .wdata(rdata2),
        .rdata(bus_rdata), .done(bus_done),
        .wb_dat_rd, .wb_ack, .wb_adr, .wb_dat_wr, .wb_cyc, .wb_stb, .wb_we
    );

endmodule

/* dv/rv_model.svh */
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// full seven-bit major opcodes
localparam logic [6:0] op7_load   = 7'b0000011;
localparam logic [6:0] op7_opimm  = 7'b0010011;
localparam logic [6:0] op7_auipc  = 7'b0010111;
localparam logic [6:0] op7_store  = 7'b0100011;
localparam logic [6:0] op7_op     = 7'b0110011;
localparam logic [6:0] op7_lui    = 7'b0110111;
localparam logic [6:0] op7_branch = 7'b1100011;
localparam logic [6:0] op7_jalr   = 7'b1100111;
localparam logic [6:0] op7_jal    = 7'b1101111;
localparam logic [31:0] self_loop = 32'h0000_006f;   // jal x0, 0

logic [7:0]  model_mem [0:mem_size-1];
int          exp_kind [$];   // 0 fetch, 1 load, 2 store
logic [31:0] exp_addr [$];
logic [31:0] exp_data [$];

function automatic logic [31:0] model_word(logic [31:0] a);
    return {model_mem[a[9:0] + 10'd3], model_mem[a[9:0] + 10'd2],
            model_mem[a[9:0] + 10'd1], model_mem[a[9:0]]};
endfunction

task automatic model_put(logic [31:0] a, logic [31:0] w);
    model_mem[a[9:0]]         = w[7:0];   // little-endian
    model_mem[a[9:0] + 10'd1] = w[15:8];
    model_mem[a[9:0] + 10'd2] = w[23:16];
    model_mem[a[9:0] + 10'd3] = w[31:24];
endtask

task automatic record_access(int kind, logic [31:0] a, logic [31:0] d);
    exp_kind.push_back(kind);
    exp_addr.push_back(a);
    exp_data.push_back(d);
endtask

function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a, b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) return $signed(a) >>> b[4:0];   // arithmetic
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// walks the image from address zero until the self-loop is fetched
task automatic run_model();
    logic [31:0] x [0:31];
    logic [31:0] pc, ins, res, next, addr, imm_i, imm_s, imm_b, imm_j;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic        wr, alt, taken;
    int          steps;
    for (int i = 0; i < 32; i++) x[i] = '0;
    pc = 32'h0;
    steps = 0;
    while (steps < 1000) begin
        ins = model_word(pc);
        record_access(0, pc, ins);
        if (ins == self_loop) break;
        rd  = ins[11:7];
        rs1 = ins[19:15];
        rs2 = ins[24:20];
        f3  = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        next = pc + 32'd4;
        wr = 1'b0;
        res = '0;
        case (ins[6:0])
            op7_op: begin
                alt = ins[30] && ((f3 == 3'd0) || (f3 == 3'd5));
                res = alu_model(f3, alt, x[rs1], x[rs2]);
                wr = 1'b1;
            end
            op7_opimm: begin
                alt = ins[30] && (f3 == 3'd5);   // srai only, no subi
                res = alu_model(f3, alt, x[rs1], imm_i);
                wr = 1'b1;
            end
            op7_lui: begin
                res = {ins[31:12], 12'b0};
                wr = 1'b1;
            end
            op7_auipc: begin
                res = pc + {ins[31:12], 12'b0};
                wr = 1'b1;
            end
            op7_load: begin
                addr = x[rs1] + imm_i;
                res = model_word(addr);
                record_access(1, addr, res);
                wr = 1'b1;
            end
            op7_store: begin
                addr = x[rs1] + imm_s;
                record_access(2, addr, x[rs2]);
                model_put(addr, x[rs2]);
            end
            op7_branch: begin
                case (f3)
                    3'd0: taken = (x[rs1] == x[rs2]);
                    3'd1: taken = (x[rs1] != x[rs2]);
                    3'd4: taken = ($signed(x[rs1]) < $signed(x[rs2]));
                    3'd5: taken = ($signed(x[rs1]) >= $signed(x[rs2]));
                    3'd6: taken = (x[rs1] < x[rs2]);
                    3'd7: taken = (x[rs1] >= x[rs2]);
                    default: taken = 1'b0;
                endcase
                if (taken) next = pc + imm_b;
            end
            op7_jal: begin
                res = pc + 32'd4;
                wr = 1'b1;
                next = pc + imm_j;
            end
            op7_jalr: begin
                next = (x[rs1] + imm_i) & ~32'd1;   // old rs1 even when rd == rs1
                res = pc + 32'd4;
                wr = 1'b1;
            end
            default: ;
        endcase
        if (wr && (rd != 5'd0)) x[rd] = res;
        pc = next;
        steps++;
    end
endtask

`endif

/* dv/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
    localparam int mem_size = 1024;
    localparam int n_random = 40;
    localparam int n_instr = n_random + 9;       // plus final stores and the loop
    localparam int worst_cycles_per_instr = 56;  // two accesses at the longest ack delay
    localparam int max_cycles = n_instr * worst_cycles_per_instr * 4;

    logic        clk;
    logic        reset;
    logic [7:0]  wb_dat_rd = 8'h00;
    logic        wb_ack = 1'b0;
    logic [31:0] wb_adr;
    logic [7:0]  wb_dat_wr;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;

    logic [7:0]  mem [0:mem_size-1];
    integer      seed = 19;
    int          n_errors = 0;
    int          n_checks = 0;

    // memory slave bookkeeping
    logic        in_beat = 1'b0;
    logic        cyc_dropped = 1'b1;
    int          delay = 0;
    int          beat = 0;
    int          acc_count = 0;
    logic        acc_we;
    logic [31:0] acc_addr;
    logic [31:0] acc_word;
    logic [31:0] hold_adr;
    logic [7:0]  hold_dat;

    `include "rv_model.svh"

    cpu i_dut (
        .clk, .reset, .wb_dat_rd, .wb_ack,
        .wb_adr, .wb_dat_wr, .wb_cyc, .wb_stb, .wb_we
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        n_errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [7:0] fill_byte(int a);
        return 8'(a * 37 + (a >> 8) * 101);
    endfunction

    task automatic put_word(int a, logic [31:0] w);
        mem[a]     = w[7:0];
        mem[a + 1] = w[15:8];
        mem[a + 2] = w[23:16];
        mem[a + 3] = w[31:24];
    endtask

    task automatic build_program();
        logic [31:0] w;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        int          kind, t;
        for (int a = 0; a < mem_size; a++) mem[a] = fill_byte(a);
        for (int i = 0; i < n_random; i++) begin
            rd  = 5'(rand_below(8));
            rs1 = 5'(rand_below(8));
            rs2 = 5'(rand_below(8));
            f3  = 3'(rand_below(8));
            imm = 12'($random(seed));
            t = i + 1 + rand_below(4);   // forward target up to the first final store
            if (t > n_random) t = n_random;
            kind = rand_below(10);
            if (i < 7) begin
                kind = 1;   // addi x1..x7 so no register is read undefined
                rd = 5'(i + 1);
                rs1 = 5'd0;
                f3 = 3'd0;
            end
            if (f3 == 3'd1) imm = {7'b0, imm[4:0]};
            if ((f3 == 3'd5) && (kind == 1)) imm = {1'b0, imm[10], 5'b0, imm[4:0]};
            boff = 13'((t - i) * 4);
            joff = 21'((t - i) * 4);
            case (kind)
                0: w = {1'b0, ((f3 == 3'd0) || (f3 == 3'd5)) ? imm[10] : 1'b0, 5'b0,
                        rs2, rs1, f3, rd, op7_op};
                1: w = {imm, rs1, f3, rd, op7_opimm};
                2: w = {20'($random(seed)), rd, op7_lui};
                3: w = {20'($random(seed)), rd, op7_auipc};
                4: w = {12'(12'h200 + 4 * rand_below(32)), 5'd0, 3'b010, rd, op7_load};
                5: begin
                    imm = 12'(12'h200 + 4 * rand_below(32));
                    w = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], op7_store};
                end
                6, 7: begin
                    if (f3[2:1] == 2'b01) f3 = 3'd0;   // no branch codes 2 and 3
                    w = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], op7_branch};
                end
                8: w = {joff[20], joff[10:1], joff[11], joff[19:12], rd, op7_jal};
                default: w = {12'(t * 4), 5'd0, 3'b000, rd, op7_jalr};
            endcase
            put_word(4 * i, w);
        end
        for (int r = 0; r < 8; r++) begin
            imm = 12'(12'h380 + 4 * r);
            put_word(4 * (n_random + r),
                     {imm[11:5], 5'(r), 5'd0, 3'b010, imm[4:0], op7_store});
        end
        put_word(4 * (n_random + 8), self_loop);
        for (int a = 0; a < mem_size; a++) model_mem[a] = mem[a];
    endtask

    task automatic finish_access();
        if (acc_count >= exp_addr.size()) begin
            report_failure("bus access beyond the end of the expected trace");
        end else begin
            check("wb_we", {31'b0, acc_we}, (exp_kind[acc_count] == 2) ? 32'd1 : 32'd0);
            check("wb_adr", acc_addr, exp_addr[acc_count]);
            check("access word", acc_word, exp_data[acc_count]);
        end
        acc_count++;
    endtask

    task automatic serve_beat();
        if (!in_beat) begin
            if (beat == 0) begin
                if (!cyc_dropped) report_failure("wb_cyc stayed high between accesses");
                cyc_dropped = 1'b0;
                acc_addr = wb_adr;
                acc_we = wb_we;
            end
            check("wb_adr", wb_adr, acc_addr + 32'(beat));
            check("wb_we", {31'b0, wb_we}, {31'b0, acc_we});
            if (wb_adr >= mem_size) report_failure("bus address outside the memory");
            hold_adr = wb_adr;
            hold_dat = wb_dat_wr;
            delay = $random(seed) & 3;
            in_beat = 1'b1;
        end else begin
            check("wb_adr", wb_adr, hold_adr);   // must hold while ack is low
            check("wb_dat_wr", {24'b0, wb_dat_wr}, {24'b0, hold_dat});
        end
        if (delay == 0) begin
            wb_ack = 1'b1;
            in_beat = 1'b0;
            if (wb_we) begin
                mem[wb_adr[9:0]] = wb_dat_wr;
                acc_word[8 * beat +: 8] = wb_dat_wr;
            end else begin
                wb_dat_rd = mem[wb_adr[9:0]];
                acc_word[8 * beat +: 8] = wb_dat_rd;
            end
            beat++;
            if (beat == 4) begin
                beat = 0;
                finish_access();
            end
        end else begin
            delay--;
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            wb_ack = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;   // ack lasts one cycle
        end else begin
            if (!wb_cyc) cyc_dropped = 1'b1;
            if (wb_stb && !wb_cyc) report_failure("wb_stb high without wb_cyc");
            if (in_beat && !(wb_cyc && wb_stb)) begin
                report_failure("wb_stb dropped before wb_ack");
            end
            if (wb_cyc && wb_stb) serve_beat();
        end
    end

    initial begin
        reset = 1'b1;
        build_program();
        run_model();
        repeat (10) @(posedge clk);
        @(negedge clk);
        check("wb_cyc", {31'b0, wb_cyc}, 32'd0);
        check("wb_stb", {31'b0, wb_stb}, 32'd0);
        reset = 1'b0;
        while (acc_count < exp_addr.size()) @(posedge clk);
        @(negedge clk);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (max_cycles) @(posedge clk);
        $display("timeout: the program did not reach its final loop in %0d cycles", max_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* flist.f */
+incdir+dv
hw/cpu_pkg.sv
hw/alu.sv
hw/decoder.sv
hw/registers.sv
hw/bus_wb8.sv
hw/control.sv
hw/cpu.sv
dv/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
BUILD_DIR ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
